/* verilog/frame_resize_params.svh */
`ifndef FRAME_RESIZE_PARAMS_SVH
`define FRAME_RESIZE_PARAMS_SVH

// Pixel and coordinate word widths
`define FRC_PIXEL_W 8
`define FRC_COORD_W 16

// Source raster size
`define FRC_SRC_WIDTH  10
`define FRC_SRC_HEIGHT 10

// Destination raster size, nearest-neighbour reduction
`define FRC_DST_WIDTH  5
`define FRC_DST_HEIGHT 5

// Line FIFO address width, depth is 2**AW and must hold one dst line
`define FRC_FIFO_AW 4

// Number of line FIFOs in the ring
`define FRC_LINE_COUNT 6

`endif

/* verilog/pixel_pkg.sv */
`include "frame_resize_params.svh"

package pixel_pkg;

  // Single pixel sample
  typedef logic [`FRC_PIXEL_W-1:0] pixel_t;

  // Raster coordinate, also used for accumulators
  typedef logic [`FRC_COORD_W-1:0] coord_t;

  // Source beat, one per cycle while valid is high
  typedef struct packed {
    logic   valid;
    pixel_t pixel;
    coord_t x;
    coord_t y;
  } src_pixel_s;

  // Kept pixel in destination coordinates
  typedef struct packed {
    logic   valid;
    pixel_t pixel;
    coord_t dst_x;
    coord_t dst_y;
    // High on the last pixel of a dst line
    logic   last;
  } dst_pixel_s;

endpackage

/* verilog/line_fifo_pkg.sv */
`include "frame_resize_params.svh"

package line_fifo_pkg;

  // FIFO occupancy, one bit wider than the address to reach full depth
  typedef logic [`FRC_FIFO_AW:0] fifo_level_t;

  // Ring index, also wide enough for the count of ready lines
  typedef logic [2:0] line_idx_t;

  // Discarded pixel counter
  typedef logic [15:0] drop_cnt_t;

  // Ring state seen by the consumer
  typedef struct packed {
    // Complete lines not yet fully read
    line_idx_t lines_ready;
    // All FIFOs hold unread lines
    logic      ring_full;
    drop_cnt_t drop_count;
  } ring_status_s;

endpackage

/* verilog/coord_scaler.sv */
`timescale 1ns/1ps
`include "frame_resize_params.svh"

module coord_scaler (
  input  logic                  clk,
  input  logic                  rst_n,
  input  pixel_pkg::src_pixel_s src,
  output pixel_pkg::dst_pixel_s kept
);

  import pixel_pkg::*;

  // Remainder of x*DST/SRC and its floor, for the previous column
  coord_t col_acc;
  coord_t col_dst;
  // Same for the current row, plus its keep decision
  coord_t row_acc;
  coord_t row_dst;
  logic   row_keep;

  coord_t col_sum;
  coord_t row_sum;
  coord_t col_acc_nxt;
  coord_t col_dst_nxt;
  coord_t row_acc_nxt;
  coord_t row_dst_nxt;
  logic   col_keep_nxt;
  logic   row_keep_nxt;

  // Column step, wrap of the accumulator means a new dst column
  always_comb
  begin
    col_sum = col_acc + coord_t'(`FRC_DST_WIDTH);
    if (src.x == '0)
    begin
      col_acc_nxt  = '0;
      col_dst_nxt  = '0;
      col_keep_nxt = 1'b1;
    end
    else if (col_sum >= coord_t'(`FRC_SRC_WIDTH))
    begin
      col_acc_nxt  = col_sum - coord_t'(`FRC_SRC_WIDTH);
      col_dst_nxt  = col_dst + 1'b1;
      col_keep_nxt = 1'b1;
    end
    else
    begin
      col_acc_nxt  = col_sum;
      col_dst_nxt  = col_dst;
      col_keep_nxt = 1'b0;
    end
  end

  // Row step only on the first column of a source line
  always_comb
  begin
    row_sum      = row_acc + coord_t'(`FRC_DST_HEIGHT);
    row_acc_nxt  = row_acc;
    row_dst_nxt  = row_dst;
    row_keep_nxt = row_keep;
    if (src.x == '0)
    begin
      if (src.y == '0)
      begin
        row_acc_nxt  = '0;
        row_dst_nxt  = '0;
        row_keep_nxt = 1'b1;
      end
      else if (row_sum >= coord_t'(`FRC_SRC_HEIGHT))
      begin
        row_acc_nxt  = row_sum - coord_t'(`FRC_SRC_HEIGHT);
        row_dst_nxt  = row_dst + 1'b1;
        row_keep_nxt = 1'b1;
      end
      else
      begin
        row_acc_nxt  = row_sum;
        row_keep_nxt = 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      col_acc  <= '0;
      col_dst  <= '0;
      row_acc  <= '0;
      row_dst  <= '0;
      row_keep <= 1'b0;
      kept     <= '0;
    end
    else
    begin
      // Accumulators only move on real source beats
      if (src.valid)
      begin
        col_acc  <= col_acc_nxt;
        col_dst  <= col_dst_nxt;
        row_acc  <= row_acc_nxt;
        row_dst  <= row_dst_nxt;
        row_keep <= row_keep_nxt;
      end
      kept.valid <= src.valid && col_keep_nxt && row_keep_nxt;
      kept.pixel <= src.pixel;
      kept.dst_x <= col_dst_nxt;
      kept.dst_y <= row_dst_nxt;
      kept.last  <= (col_dst_nxt == coord_t'(`FRC_DST_WIDTH - 1));
    end
  end

endmodule

/* verilog/line_fifo.sv */
`timescale 1ns/1ps
`include "frame_resize_params.svh"

module line_fifo (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       push,
  input  logic                       pop,
  input  pixel_pkg::pixel_t          wdata,
  output pixel_pkg::pixel_t          rdata,
  output line_fifo_pkg::fifo_level_t level,
  output logic                       empty
);

  import pixel_pkg::*;
  import line_fifo_pkg::*;

  localparam int DEPTH = 1 << `FRC_FIFO_AW;

  // Storage, one dst line fits with room to spare
  pixel_t                  mem [DEPTH];
  logic [`FRC_FIFO_AW-1:0] wr_ptr;
  logic [`FRC_FIFO_AW-1:0] rd_ptr;
  fifo_level_t             count;

  logic full;
  logic do_push;
  logic do_pop;

  assign full    = (count == fifo_level_t'(DEPTH));
  assign empty   = (count == '0);
  assign level   = count;
  // Overflow and underflow requests are ignored
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= wdata;
  end

  // Read word lands one cycle after the pop
  always_ff @(posedge clk)
  begin
    if (do_pop)
      rdata <= mem[rd_ptr];
  end

endmodule

/* verilog/line_store.sv */
`timescale 1ns/1ps
`include "frame_resize_params.svh"

module line_store (
  input  logic                        clk,
  input  logic                        rst_n,
  input  pixel_pkg::dst_pixel_s       kept,
  input  logic                        rd_en,
  output pixel_pkg::dst_pixel_s       out,
  output line_fifo_pkg::ring_status_s status,
  output logic                        frame_done
);

  import pixel_pkg::*;
  import line_fifo_pkg::*;

  localparam int DEPTH = 1 << `FRC_FIFO_AW;

  // Per-FIFO handshake wires
  logic [`FRC_LINE_COUNT-1:0] push_v;
  logic [`FRC_LINE_COUNT-1:0] pop_v;
  logic [`FRC_LINE_COUNT-1:0] empty_v;
  pixel_t                     rdata_v [`FRC_LINE_COUNT];
  fifo_level_t                level_v [`FRC_LINE_COUNT];

  // Ring pointers and counters
  line_idx_t wr_line;
  line_idx_t rd_line;
  line_idx_t lines_ready;
  drop_cnt_t drop_count;
  logic      dropping;
  logic      ring_full;

  // dst_y tag of each stored line
  coord_t line_y [`FRC_LINE_COUNT];

  // Read side, rd_cnt is the dst_x of the next pop
  coord_t    rd_cnt;
  line_idx_t rd_sel_q;
  logic      out_valid_q;
  coord_t    out_x_q;
  coord_t    out_y_q;
  logic      out_last_q;

  logic line_start;
  logic drop_line;
  logic no_room;
  logic discard;
  logic accept;
  logic wr_done;
  logic rd_fire;
  logic rd_done;

  assign ring_full  = (lines_ready == line_idx_t'(`FRC_LINE_COUNT));
  assign line_start = kept.valid && (kept.dst_x == '0);
  // Drop decision is taken once per line, at its first pixel
  assign drop_line  = line_start ? ring_full : dropping;
  assign no_room    = (level_v[wr_line] >= fifo_level_t'(DEPTH));
  assign discard    = kept.valid && (drop_line || no_room);
  assign accept     = kept.valid && !discard;
  assign wr_done    = accept && kept.last;

  assign rd_fire = rd_en && (lines_ready != '0) && !empty_v[rd_line];
  assign rd_done = rd_fire && (rd_cnt == coord_t'(`FRC_DST_WIDTH - 1));

  for (genvar i = 0; i < `FRC_LINE_COUNT; i++)
  begin : g_line
    assign push_v[i] = accept && (wr_line == line_idx_t'(i));
    assign pop_v[i]  = rd_fire && (rd_line == line_idx_t'(i));

    line_fifo line_fifo_i (
      .clk   (clk),
      .rst_n (rst_n),
      .push  (push_v[i]),
      .pop   (pop_v[i]),
      .wdata (kept.pixel),
      .rdata (rdata_v[i]),
      .level (level_v[i]),
      .empty (empty_v[i])
    );
  end

  // Write side and ring bookkeeping
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_line     <= '0;
      rd_line     <= '0;
      lines_ready <= '0;
      drop_count  <= '0;
      dropping    <= 1'b0;
      rd_cnt      <= '0;
      frame_done  <= 1'b0;
    end
    else
    begin
      if (line_start)
        dropping <= ring_full;
      if (discard && (drop_count != '1))
        drop_count <= drop_count + 1'b1;
      if (wr_done)
        wr_line <= (wr_line == line_idx_t'(`FRC_LINE_COUNT - 1)) ? '0 : wr_line + 1'b1;
      if (rd_fire)
        rd_cnt <= rd_done ? '0 : rd_cnt + 1'b1;
      if (rd_done)
        rd_line <= (rd_line == line_idx_t'(`FRC_LINE_COUNT - 1)) ? '0 : rd_line + 1'b1;
      case ({wr_done, rd_done})
        2'b10:   lines_ready <= lines_ready + 1'b1;
        2'b01:   lines_ready <= lines_ready - 1'b1;
        default: lines_ready <= lines_ready;
      endcase
      // Frame end seen at the store, also when its line was dropped
      frame_done <= kept.valid && kept.last
                    && (kept.dst_y == coord_t'(`FRC_DST_HEIGHT - 1));
    end
  end

  // Line tag captured with the first accepted pixel
  always_ff @(posedge clk)
  begin
    if (accept && line_start)
      line_y[wr_line] <= kept.dst_y;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      out_valid_q <= 1'b0;
    else
      out_valid_q <= rd_fire;
  end

  // Coordinates of the popped word, aligned with FIFO rdata
  always_ff @(posedge clk)
  begin
    if (rd_fire)
    begin
      rd_sel_q   <= rd_line;
      out_x_q    <= rd_cnt;
      out_y_q    <= line_y[rd_line];
      out_last_q <= rd_done;
    end
  end

  assign out = '{valid: out_valid_q,
                 pixel: rdata_v[rd_sel_q],
                 dst_x: out_x_q,
                 dst_y: out_y_q,
                 last:  out_last_q};

  assign status = '{lines_ready: lines_ready,
                    ring_full:   ring_full,
                    drop_count:  drop_count};

endmodule

/* verilog/frame_resize_top.sv */
`timescale 1ns/1ps

module frame_resize_top (
  input  logic                        clk,
  input  logic                        rst_n,
  // Source raster, one beat per cycle
  input  pixel_pkg::src_pixel_s       src,
  // Consumer read strobe
  input  logic                        rd_en,
  output pixel_pkg::dst_pixel_s       out,
  output line_fifo_pkg::ring_status_s status,
  output logic                        frame_done
);

  import pixel_pkg::*;

  // Kept pixels in dst coordinates
  dst_pixel_s kept;

  // Nearest-neighbour selection
  coord_scaler scaler_i (
    .clk   (clk),
    .rst_n (rst_n),
    .src   (src),
    .kept  (kept)
  );

  // Line ring and read port
  line_store store_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .kept       (kept),
    .rd_en      (rd_en),
    .out        (out),
    .status     (status),
    .frame_done (frame_done)
  );

endmodule

/* testbench/frame_resize_checker.sv */
`timescale 1ns/1ps

module frame_resize_checker (
  input logic                        clk,
  input logic                        rst_n,
  input logic                        rd_en,
  input pixel_pkg::dst_pixel_s       out,
  input line_fifo_pkg::ring_status_s status,
  input logic                        frame_done
);

  // Popped word only after a strobe while a line was ready
  read_follows_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    out.valid |-> $past(rd_en && (status.lines_ready != 3'd0)))
    else $error("out.valid without a read strobe on a ready line");

  // Drop counter only counts up
  drops_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
    status.drop_count >= $past(status.drop_count))
    else $error("drop_count went down");

  // End of frame marker, one cycle wide
  frame_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    frame_done |=> !frame_done)
    else $error("frame_done stayed high for more than one cycle");

endmodule

bind frame_resize_top frame_resize_checker checker_i (
  .clk        (clk),
  .rst_n      (rst_n),
  .rd_en      (rd_en),
  .out        (out),
  .status     (status),
  .frame_done (frame_done)
);

/* testbench/frame_resize_tb.sv */
`timescale 1ns/1ps
`include "frame_resize_params.svh"

module frame_resize_tb;

  import pixel_pkg::*;
  import line_fifo_pkg::*;

  localparam int SW = `FRC_SRC_WIDTH;
  localparam int SH = `FRC_SRC_HEIGHT;
  localparam int DW = `FRC_DST_WIDTH;
  localparam int DH = `FRC_DST_HEIGHT;
  localparam int LINES = `FRC_LINE_COUNT;
  localparam int FRAME_GAP = 40;
  localparam int DRAIN_MAX = 64;
  localparam int RESET_CYCLES = 16;
  localparam int READ_ALWAYS = 0;
  localparam int READ_EVERY_N = 1;
  localparam int READ_PAUSED = 2;
  localparam int NUM_ROWS = 5;

  // param is N for every-Nth reads, or the count of paused frames
  typedef struct packed {
    int         frames;
    int         mode;
    int         param;
    logic [7:0] start;
    logic       rnd;
  } test_row_s;

  test_row_s rows [NUM_ROWS] = '{
    '{frames: 3, mode: READ_ALWAYS,  param: 0, start: 8'h00, rnd: 1'b0},
    '{frames: 2, mode: READ_EVERY_N, param: 3, start: 8'h40, rnd: 1'b0},
    '{frames: 3, mode: READ_PAUSED,  param: 2, start: 8'h80, rnd: 1'b0},
    '{frames: 2, mode: READ_ALWAYS,  param: 0, start: 8'h00, rnd: 1'b1},
    '{frames: 2, mode: READ_EVERY_N, param: 5, start: 8'h20, rnd: 1'b1}
  };

  logic         clk;
  logic         rst_n;
  src_pixel_s   src;
  logic         rd_en;
  dst_pixel_s   out;
  ring_status_s status;
  logic         frame_done;

  // Reference model, state expected right after the next clock edge
  dst_pixel_s m_kept;
  dst_pixel_s m_out;
  logic       m_out_valid;
  logic       m_frame_done;
  logic       m_dropping;
  int         m_ready;
  int         m_rd_cnt;
  int         m_drops;
  // Accepted pixels in ring order
  dst_pixel_s exp_q [$];

  int   seed;
  int   error_count;
  int   frames_seen;
  logic ring_full_seen;
  int   cycle_count;
  int   cycle_limit;

  frame_resize_top dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .src        (src),
    .rd_en      (rd_en),
    .out        (out),
    .status     (status),
    .frame_done (frame_done)
  );

  always #5 clk = ~clk;

  task automatic halt_with_failure();
    error_count++;
    $display("Some tests failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Fail %s: got %h expected %h", name, got, exp);
    halt_with_failure();
  endtask

  task automatic report_problem(input string msg);
    $display("%s", msg);
    halt_with_failure();
  endtask

  // Stops runaway runs, including a drain that never finishes
  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit)
      report_problem("Timeout: the run went past its cycle limit");
  end

  function automatic int cycle_budget();
    int total;
    total = RESET_CYCLES + 16;
    for (int i = 0; i < NUM_ROWS; i++)
      total += rows[i].frames * (SW * SH + FRAME_GAP) + DRAIN_MAX;
    return total;
  endfunction

  // Nearest-neighbour rule, kept when floor(c*D/S) steps or c is 0
  function automatic dst_pixel_s scale_beat(input src_pixel_s s);
    dst_pixel_s k;
    int         dx;
    int         dy;
    logic       keep_x;
    logic       keep_y;
    dx     = (int'(s.x) * DW) / SW;
    dy     = (int'(s.y) * DH) / SH;
    keep_x = (s.x == 0) || (dx != ((int'(s.x) - 1) * DW) / SW);
    keep_y = (s.y == 0) || (dy != ((int'(s.y) - 1) * DH) / SH);
    k.valid = s.valid && keep_x && keep_y;
    k.pixel = s.pixel;
    k.dst_x = coord_t'(dx);
    k.dst_y = coord_t'(dy);
    k.last  = (dx == DW - 1);
    return k;
  endfunction

  function automatic logic read_enable(input int mode, input int param,
                                       input int frame, input int cyc);
    case (mode)
      READ_EVERY_N: return (cyc % param) == 0;
      READ_PAUSED:  return frame >= param;
      default:      return 1'b1;
    endcase
  endfunction

  // Ring rule: drop whole lines that start on a full ring
  task automatic model_step(input src_pixel_s s, input logic r);
    logic ring_full;
    logic line_start;
    logic drop_line;
    logic accept;
    logic wr_done;
    logic rd_fire;
    logic rd_done;
    ring_full  = (m_ready == LINES);
    line_start = m_kept.valid && (m_kept.dst_x == 0);
    drop_line  = line_start ? ring_full : m_dropping;
    accept     = m_kept.valid && !drop_line;
    wr_done    = accept && m_kept.last;
    rd_fire    = r && (m_ready != 0);
    rd_done    = rd_fire && (m_rd_cnt == DW - 1);
    m_out_valid = rd_fire;
    if (rd_fire)
    begin
      if (exp_q.size() == 0)
        report_problem("Model popped a pixel with no line stored");
      m_out    = exp_q.pop_front();
      m_rd_cnt = rd_done ? 0 : m_rd_cnt + 1;
    end
    if (accept)
      exp_q.push_back(m_kept);
    if (line_start)
      m_dropping = ring_full;
    if (m_kept.valid && drop_line)
      m_drops++;
    m_ready      = m_ready + int'(wr_done) - int'(rd_done);
    m_frame_done = m_kept.valid && m_kept.last && (m_kept.dst_y == DH - 1);
    m_kept       = scale_beat(s);
  endtask

  task automatic check_outputs();
    assert (out.valid == m_out_valid)
      else report_mismatch("out.valid", out.valid, m_out_valid);
    if (m_out_valid)
    begin
      assert (out.pixel == m_out.pixel)
        else report_mismatch("out.pixel", out.pixel, m_out.pixel);
      assert (out.dst_x == m_out.dst_x)
        else report_mismatch("out.dst_x", out.dst_x, m_out.dst_x);
      assert (out.dst_y == m_out.dst_y)
        else report_mismatch("out.dst_y", out.dst_y, m_out.dst_y);
      assert (out.last == m_out.last)
        else report_mismatch("out.last", out.last, m_out.last);
    end
    assert (frame_done == m_frame_done)
      else report_mismatch("frame_done", frame_done, m_frame_done);
    assert (status.lines_ready == 3'(m_ready))
      else report_mismatch("status.lines_ready", status.lines_ready, m_ready);
    assert (status.ring_full == (m_ready == LINES))
      else report_mismatch("status.ring_full", status.ring_full, m_ready == LINES);
    assert (status.drop_count == 16'(m_drops))
      else report_mismatch("status.drop_count", status.drop_count, m_drops);
    if (frame_done)
      frames_seen++;
    if (status.ring_full)
      ring_full_seen = 1'b1;
  endtask

  // One clock, inputs change 1 ns after the edge
  task automatic cycle_step(input src_pixel_s s, input logic r);
    @(posedge clk);
    #1;
    check_outputs();
    model_step(s, r);
    src   = s;
    rd_en = r;
  endtask

  task automatic run_row(input int idx);
    test_row_s  row;
    src_pixel_s s;
    int         cyc;
    int         drops_before;
    row            = rows[idx];
    cyc            = 0;
    drops_before   = int'(status.drop_count);
    frames_seen    = 0;
    ring_full_seen = 1'b0;
    for (int f = 0; f < row.frames; f++)
    begin
      for (int y = 0; y < SH; y++)
        for (int x = 0; x < SW; x++)
        begin
          s.valid = 1'b1;
          s.x     = coord_t'(x);
          s.y     = coord_t'(y);
          if (row.rnd)
            s.pixel = row.start ^ 8'($random(seed));
          else
            s.pixel = 8'(row.start + f * SW * SH + y * SW + x);
          cycle_step(s, read_enable(row.mode, row.param, f, cyc));
          cyc++;
        end
      // Idle beats let the last line of the frame complete
      repeat (FRAME_GAP)
      begin
        cycle_step('0, read_enable(row.mode, row.param, f, cyc));
        cyc++;
      end
    end
    // Drain with reads on until the model expects an empty ring
    while ((m_ready != 0) || m_out_valid)
      cycle_step('0, 1'b1);
    // Next edge must show no ready line and an idle read port
    cycle_step('0, 1'b1);
    assert (frames_seen == row.frames)
      else report_mismatch("frame_done count", frames_seen, row.frames);
    if (row.mode == READ_PAUSED)
    begin
      assert (ring_full_seen)
        else report_problem("ring_full never rose while reads were paused");
      assert (int'(status.drop_count) > drops_before)
        else report_problem("No pixels were dropped while reads were paused");
    end
  endtask

  initial
  begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    src          = '0;
    rd_en        = 1'b0;
    seed         = 32'h933a8078;
    error_count  = 0;
    cycle_count  = 0;
    cycle_limit  = cycle_budget();
    m_kept       = '0;
    m_out        = '0;
    m_out_valid  = 1'b0;
    m_frame_done = 1'b0;
    m_dropping   = 1'b0;
    m_ready      = 0;
    m_rd_cnt     = 0;
    m_drops      = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    assert (!out.valid && !frame_done)
      else report_problem("out.valid or frame_done high after reset");
    assert (status == '0)
      else report_mismatch("status", status, 0);
    // Reads with nothing stored must return no data
    repeat (10) cycle_step('0, 1'b1);
    for (int i = 0; i < NUM_ROWS; i++)
      run_row(i);
    if (error_count == 0)
    begin
      $display("All tests passed");
      $finish;
    end
    else
    begin
      halt_with_failure();
    end
  end

endmodule

/* frame_resize.f */
+incdir+verilog
verilog/pixel_pkg.sv
verilog/line_fifo_pkg.sv
verilog/coord_scaler.sv
verilog/line_fifo.sv
verilog/line_store.sv
verilog/frame_resize_top.sv
testbench/frame_resize_checker.sv
testbench/frame_resize_tb.sv

/* Bender.yml */
package:
  name: frame_resize

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/pixel_pkg.sv
      - verilog/line_fifo_pkg.sv
      - verilog/coord_scaler.sv
      - verilog/line_fifo.sv
      - verilog/line_store.sv
      - verilog/frame_resize_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/frame_resize_checker.sv
      - testbench/frame_resize_tb.sv
